/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// First fetch address after reset
`define CPU_RESET_PC 32'hbfc0_0000

// Architectural register file
`define CPU_NREGS    32
`define CPU_XLEN     32

`endif

/* cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [4:0]           reg_addr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_t    funct;
    } instr_r_t;

    typedef struct packed {
        opcode_t     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_NONE   = 2'b00,
        FWD_FROM_W = 2'b01,
        FWD_FROM_M = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        logic f;
        logic d;
        logic e;
        logic m;
        logic w;
    } stage_vec_t;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        logic      uses_rs;
        logic      uses_rt;
        logic      is_branch_or_jr;   // Operands compared in decode
    } d_sum_t;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t reg_waddr;
        logic      regwrite;
        logic      memtoreg;
    } e_sum_t;

    typedef struct packed {
        reg_addr_t reg_waddr;
        logic      regwrite;
        logic      memtoreg;
    } m_sum_t;

    typedef m_sum_t w_sum_t;   // Same fields one stage later

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf, word_t m, word_t w);
        case (sel)
            FWD_FROM_M: return m;
            FWD_FROM_W: return w;
            default:    return rf;
        endcase
    endfunction

endpackage

/* hazard_if.sv */
`timescale 1ns/1ps

interface hazard_if import cpu_pkg::*; ();

    d_sum_t     d_sum;
    e_sum_t     e_sum;
    m_sum_t     m_sum;
    w_sum_t     w_sum;

    fwd_sel_t   d_fwd_a;    // Branch operands in decode
    fwd_sel_t   d_fwd_b;
    fwd_sel_t   e_fwd_a;    // ALU operands in execute
    fwd_sel_t   e_fwd_b;

    stage_vec_t stall;
    stage_vec_t flush;
    logic       redirect;   // Taken branch or jump in decode

    modport decode (
        output d_sum,
        output redirect,
        input  d_fwd_a,
        input  d_fwd_b
    );

    modport execute (
        output e_sum,
        input  e_fwd_a,
        input  e_fwd_b
    );

    modport pipe (
        output m_sum,
        output w_sum,
        input  stall,
        input  flush,
        input  redirect
    );

    modport unit (
        input  d_sum, e_sum, m_sum, w_sum, redirect,
        output d_fwd_a, d_fwd_b, e_fwd_a, e_fwd_b, stall, flush
    );

endinterface

/* regfile.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [4:0]           ra1,
    input  logic [4:0]           ra2,
    input  logic                 we,
    input  logic [4:0]           wa,
    input  logic [`CPU_XLEN-1:0] wd,
    output logic [`CPU_XLEN-1:0] rd1,
    output logic [`CPU_XLEN-1:0] rd2
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end
        else if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    // Register 0 reads zero and a same-cycle write passes straight through
    assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  instr_u    instr,
    input  word_t     pc,
    input  logic      valid,
    input  word_t     m_result,
    input  word_t     w_result,
    hazard_if.decode  hz,
    output reg_addr_t rf_ra1,
    output reg_addr_t rf_ra2,
    input  word_t     rf_rd1,
    input  word_t     rf_rd2,
    output alu_op_t   alu_op,
    output logic      use_imm,
    output word_t     imm,
    output logic      memtoreg,
    output logic      memwrite,
    output logic      regwrite,
    output reg_addr_t reg_waddr,
    output word_t     opa,
    output word_t     opb,
    output word_t     redirect_pc
);

    logic      wr, rd_mem, wr_mem;
    logic      uses_rs, uses_rt, is_br, is_j, taken;
    reg_addr_t dest;
    word_t     br_a, br_b, pc_plus4;

    always_comb
    begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        wr      = 1'b0;
        rd_mem  = 1'b0;
        wr_mem  = 1'b0;
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        is_br   = 1'b0;
        is_j    = 1'b0;
        dest    = instr.i.rt;            // I-type writes rt
        case (instr.r.op)
            OP_SPECIAL:
            begin
                dest    = instr.r.rd;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                wr      = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: wr = 1'b0;  // Unknown funct acts as nop
                endcase
            end
            OP_ADDIU, OP_LW:
            begin
                use_imm = 1'b1;
                uses_rs = 1'b1;
                wr      = 1'b1;
                rd_mem  = (instr.i.op == OP_LW);
            end
            OP_SW:
            begin
                use_imm = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;          // Store data
                wr_mem  = 1'b1;
            end
            OP_BEQ, OP_BNE:
            begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                is_br   = 1'b1;
            end
            OP_J:    is_j = 1'b1;
            default: ;
        endcase
    end

    assign rf_ra1    = instr.r.rs;
    assign rf_ra2    = instr.r.rt;
    assign imm       = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign opa       = rf_rd1;
    assign opb       = rf_rd2;
    assign regwrite  = valid && wr && dest != 5'd0;
    assign memtoreg  = valid && rd_mem;
    assign memwrite  = valid && wr_mem;
    assign reg_waddr = dest;

    assign hz.d_sum = '{rs: instr.r.rs, rt: instr.r.rt,
                        uses_rs: valid && uses_rs, uses_rt: valid && uses_rt,
                        is_branch_or_jr: valid && is_br};

    // Compare operands may still be in flight in M or W
    assign br_a     = fwd_mux(hz.d_fwd_a, rf_rd1, m_result, w_result);
    assign br_b     = fwd_mux(hz.d_fwd_b, rf_rd2, m_result, w_result);
    assign taken    = (instr.i.op == OP_BEQ) ? (br_a == br_b) : (br_a != br_b);
    assign pc_plus4 = pc + 32'd4;

    assign hz.redirect = valid && (is_j || (is_br && taken));
    assign redirect_pc = is_j ? {pc_plus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm16, 2'b00}
                              : pc_plus4 + {imm[29:0], 2'b00};

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic      valid,
    input  alu_op_t   alu_op,
    input  logic      use_imm,
    input  word_t     imm,
    input  word_t     opa,
    input  word_t     opb,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  reg_addr_t reg_waddr,
    input  logic      regwrite,
    input  logic      memtoreg,
    input  word_t     m_result,
    input  word_t     w_result,
    hazard_if.execute hz,
    output word_t     result,
    output word_t     store_data
);

    word_t a, b_reg, b;

    assign a     = fwd_mux(hz.e_fwd_a, opa, m_result, w_result);
    assign b_reg = fwd_mux(hz.e_fwd_b, opb, m_result, w_result);
    assign b     = use_imm ? imm : b_reg;    // Loads and stores add the offset here

    assign store_data = b_reg;

    always_comb
    begin
        case (alu_op)
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = word_t'($signed(a) < $signed(b));
            default: result = a + b;
        endcase
    end

    assign hz.e_sum = '{rs: rs, rt: rt, reg_waddr: reg_waddr,
                        regwrite: valid && regwrite, memtoreg: valid && memtoreg};

endmodule

/* hazard.sv */
`timescale 1ns/1ps

module hazard import cpu_pkg::*; (
    hazard_if.unit hz,
    input  logic   imem_busy,
    input  logic   dmem_busy
);

    logic       lw_stall, br_stall, redirect_go;
    logic [9:0] stall_flush;

    // Closest producer wins, r0 never forwards
    function automatic fwd_sel_t pick(reg_addr_t src, m_sum_t m, w_sum_t w);
        if (src == 5'd0)
            return FWD_NONE;
        if (m.regwrite && m.reg_waddr == src)
            return FWD_FROM_M;
        if (w.regwrite && w.reg_waddr == src)
            return FWD_FROM_W;
        return FWD_NONE;
    endfunction

    function automatic logic reads(d_sum_t d, reg_addr_t a);
        return a != 5'd0 && ((d.uses_rs && d.rs == a) || (d.uses_rt && d.rt == a));
    endfunction

    assign hz.d_fwd_a = pick(hz.d_sum.rs, hz.m_sum, hz.w_sum);
    assign hz.d_fwd_b = pick(hz.d_sum.rt, hz.m_sum, hz.w_sum);
    assign hz.e_fwd_a = pick(hz.e_sum.rs, hz.m_sum, hz.w_sum);
    assign hz.e_fwd_b = pick(hz.e_sum.rt, hz.m_sum, hz.w_sum);

    assign lw_stall = hz.e_sum.memtoreg && reads(hz.d_sum, hz.e_sum.reg_waddr);

    // Branch compares in decode, so an ALU result in E or a load in M is too late
    assign br_stall = hz.d_sum.is_branch_or_jr &&
                      ((hz.e_sum.regwrite && reads(hz.d_sum, hz.e_sum.reg_waddr)) ||
                       (hz.m_sum.memtoreg && reads(hz.d_sum, hz.m_sum.reg_waddr)));

    assign redirect_go = hz.redirect && !lw_stall && !br_stall;

    assign {hz.stall, hz.flush} = stall_flush;

    always_comb
    begin
        if (dmem_busy)
            stall_flush = 10'b11111_00000;
        else if (imem_busy && hz.redirect)
            stall_flush = 10'b11111_00000;   // Keep the redirect until fetch is free
        else if (imem_busy)
            stall_flush = 10'b11000_00100;
        else if (redirect_go)
            stall_flush = 10'b00000_01000;   // Drop the wrong-path fetch
        else if (lw_stall || br_stall)
            stall_flush = 10'b11000_00100;
        else
            stall_flush = 10'b0;
    end

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    output word_t     imem_addr,
    input  word_t     imem_rdata,
    input  logic      imem_busy,
    output logic      dmem_req,
    output logic      dmem_we,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    input  word_t     dmem_rdata,
    input  logic      dmem_busy,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    hazard_if hz();

    word_t     pc;
    logic      d_valid;
    word_t     d_pc;
    instr_u    d_instr;

    reg_addr_t rf_ra1, rf_ra2, dec_waddr;
    word_t     rf_rd1, rf_rd2, dec_imm, dec_opa, dec_opb, redirect_pc;
    alu_op_t   dec_alu_op;
    logic      dec_use_imm, dec_memtoreg, dec_memwrite, dec_regwrite;

    logic      e_valid, e_use_imm, e_memtoreg, e_memwrite, e_regwrite;
    alu_op_t   e_alu_op;
    word_t     e_imm, e_opa, e_opb, ex_result, ex_store;
    reg_addr_t e_rs, e_rt, e_waddr;

    logic      m_valid, m_memtoreg, m_memwrite, m_regwrite;
    logic      m_done;             // Access already finished while M was held
    word_t     m_alu, m_store, m_rdata_q, m_load_data;
    reg_addr_t m_waddr;

    logic      w_valid, w_regwrite, w_memtoreg;
    word_t     w_result;
    reg_addr_t w_waddr;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc      <= `CPU_RESET_PC;
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            m_valid <= 1'b0;
            w_valid <= 1'b0;
            m_done  <= 1'b0;
        end
        else
        begin
            if (!hz.stall.f)
                pc <= hz.redirect ? redirect_pc : pc + 32'd4;
            if (!hz.stall.d)
                d_valid <= !hz.flush.d;
            if (!hz.stall.e)
                e_valid <= d_valid && !hz.flush.e;
            if (!hz.stall.m)
                m_valid <= e_valid && !hz.flush.m;
            if (!hz.stall.w)
                w_valid <= m_valid && !hz.flush.w;
            if (!hz.stall.m)
                m_done <= 1'b0;
            else if (dmem_req && !dmem_busy)
                m_done <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!hz.stall.d)
        begin
            d_pc    <= pc;
            d_instr <= imem_rdata;
        end
        if (!hz.stall.e)
        begin
            e_alu_op   <= dec_alu_op;
            e_use_imm  <= dec_use_imm;
            e_imm      <= dec_imm;
            e_opa      <= dec_opa;
            e_opb      <= dec_opb;
            e_rs       <= rf_ra1;
            e_rt       <= rf_ra2;
            e_waddr    <= dec_waddr;
            e_regwrite <= dec_regwrite;
            e_memtoreg <= dec_memtoreg;
            e_memwrite <= dec_memwrite;
        end
        if (!hz.stall.m)
        begin
            m_alu      <= ex_result;
            m_store    <= ex_store;
            m_waddr    <= e_waddr;
            m_regwrite <= e_regwrite;
            m_memtoreg <= e_memtoreg;
            m_memwrite <= e_memwrite;
        end
        if (dmem_req && !dmem_busy)
            m_rdata_q <= dmem_rdata;
        if (!hz.stall.w)
        begin
            w_result   <= m_memtoreg ? m_load_data : m_alu;
            w_waddr    <= m_waddr;
            w_regwrite <= m_regwrite;
            w_memtoreg <= m_memtoreg;
        end
    end

    assign m_load_data = m_done ? m_rdata_q : dmem_rdata;

    assign imem_addr  = pc;
    assign dmem_req   = m_valid && (m_memtoreg || m_memwrite) && !m_done;
    assign dmem_we    = dmem_req && m_memwrite;
    assign dmem_addr  = m_alu;
    assign dmem_wdata = m_store;

    // A held W retires once, in the cycle the stall lifts
    assign wb_valid = w_valid && w_regwrite && !hz.stall.w;
    assign wb_addr  = w_waddr;
    assign wb_data  = w_result;

    assign hz.m_sum = '{reg_waddr: m_waddr, regwrite: m_valid && m_regwrite,
                        memtoreg: m_valid && m_memtoreg};
    assign hz.w_sum = '{reg_waddr: w_waddr, regwrite: w_valid && w_regwrite,
                        memtoreg: w_valid && w_memtoreg};

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rf_ra1),
        .ra2   (rf_ra2),
        .we    (wb_valid),
        .wa    (w_waddr),
        .wd    (w_result),
        .rd1   (rf_rd1),
        .rd2   (rf_rd2)
    );

    decode_stage u_decode (
        .instr       (d_instr),
        .pc          (d_pc),
        .valid       (d_valid),
        .m_result    (m_alu),
        .w_result    (w_result),
        .hz          (hz.decode),
        .rf_ra1      (rf_ra1),
        .rf_ra2      (rf_ra2),
        .rf_rd1      (rf_rd1),
        .rf_rd2      (rf_rd2),
        .alu_op      (dec_alu_op),
        .use_imm     (dec_use_imm),
        .imm         (dec_imm),
        .memtoreg    (dec_memtoreg),
        .memwrite    (dec_memwrite),
        .regwrite    (dec_regwrite),
        .reg_waddr   (dec_waddr),
        .opa         (dec_opa),
        .opb         (dec_opb),
        .redirect_pc (redirect_pc)
    );

    execute_stage u_execute (
        .valid      (e_valid),
        .alu_op     (e_alu_op),
        .use_imm    (e_use_imm),
        .imm        (e_imm),
        .opa        (e_opa),
        .opb        (e_opb),
        .rs         (e_rs),
        .rt         (e_rt),
        .reg_waddr  (e_waddr),
        .regwrite   (e_regwrite),
        .memtoreg   (e_memtoreg),
        .m_result   (m_alu),
        .w_result   (w_result),
        .hz         (hz.execute),
        .result     (ex_result),
        .store_data (ex_store)
    );

    hazard u_hazard (
        .hz        (hz.unit),
        .imem_busy (imem_busy),
        .dmem_busy (dmem_busy)
    );

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;

    localparam int CLK_PERIOD       = 8;
    localparam int RESET_CYCLES     = 8;
    localparam int N_INSTR          = 200;
    localparam int CYCLES_PER_INSTR = 20;
    localparam int DRAIN_CYCLES     = 40;
    localparam int DMEM_WORDS       = 256;
    localparam int TIMEOUT_NS       =
        (N_INSTR * CYCLES_PER_INSTR + RESET_CYCLES + DRAIN_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] LOOP_PC = `CPU_RESET_PC + 32'(4 * (N_INSTR - 1));

    // MIPS encodings
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_SLT      = 6'h2a;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr, imem_rdata;
    logic        imem_busy;
    logic        dmem_req, dmem_we, dmem_busy;
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] prog [N_INSTR];
    logic [31:0] dmem [DMEM_WORDS];        // Memory seen by the DUT
    logic [31:0] ref_dmem [DMEM_WORDS];    // Memory of the ISA model
    logic [31:0] ref_regs [32];

    logic [4:0]  exp_wb_addr [$];
    logic [31:0] exp_wb_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    int          wb_count, st_count, model_wb_total, model_st_total;

    cpu_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_busy  (imem_busy),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_busy  (dmem_busy),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h3c5a_0f96;
    endfunction

    function automatic logic [31:0] r_type_word(logic [5:0] funct, logic [4:0] rs,
                                                logic [4:0] rt, logic [4:0] rd);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type_word(logic [5:0] op, logic [4:0] rs,
                                                logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(int target);
        logic [31:0] addr;
        addr = `CPU_RESET_PC + 32'(4 * target);
        return {OPC_J, addr[27:2]};
    endfunction

    // Few registers so that hazards are frequent
    function automatic logic [4:0] small_reg();
        return 5'($urandom_range(0, 7));
    endfunction

    function automatic logic [5:0] pick_funct();
        case ($urandom_range(0, 4))
            0:       return FN_ADDU;
            1:       return FN_SUBU;
            2:       return FN_AND;
            3:       return FN_OR;
            default: return FN_SLT;
        endcase
    endfunction

    task automatic build_program();
        int         kind, lim, off;
        logic [4:0] rs, rt;
        prog[0] = i_type_word(OPC_ADDIU, 5'd0, 5'd29, 16'h0100);   // Data base in r29
        for (int i = 1; i < N_INSTR - 1; i++)
        begin
            kind = $urandom_range(0, 99);
            lim  = (N_INSTR - 2 - i < 4) ? N_INSTR - 2 - i : 4;    // Targets stay in range
            off  = $urandom_range(0, lim);
            rs   = small_reg();
            rt   = ($urandom_range(0, 3) == 0) ? rs : small_reg();
            if (kind < 35)
                prog[i] = r_type_word(pick_funct(), rs, rt, small_reg());
            else if (kind < 55)
                prog[i] = i_type_word(OPC_ADDIU, rs, rt, 16'($urandom_range(0, 40) - 12));
            else if (kind < 70)
                prog[i] = i_type_word(OPC_LW, 5'd29, rt, 16'(4 * $urandom_range(0, 31) - 64));
            else if (kind < 82)
                prog[i] = i_type_word(OPC_SW, 5'd29, rt, 16'(4 * $urandom_range(0, 31) - 64));
            else if (kind < 96)
                prog[i] = i_type_word((kind < 89) ? OPC_BEQ : OPC_BNE, rs, rt, 16'(off));
            else
                prog[i] = jump_word(i + 1 + off);
        end
        prog[N_INSTR - 1] = jump_word(N_INSTR - 1);                 // Self loop
    endtask

    task automatic record_write(logic [4:0] r, logic [31:0] v);
        if (r != 5'd0)
        begin
            ref_regs[r] = v;
            exp_wb_addr.push_back(r);
            exp_wb_data.push_back(v);
        end
    endtask

    // In-order ISA execution of the program
    task automatic run_model();
        logic [31:0] pc, nxt, ins, imm, a, b, addr;
        logic [4:0]  rs, rt, rd;
        int          steps;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        pc    = `CPU_RESET_PC;
        steps = 0;
        while (pc != LOOP_PC && steps < N_INSTR)
        begin
            ins  = prog[(pc - `CPU_RESET_PC) >> 2];
            rs   = ins[25:21];
            rt   = ins[20:16];
            rd   = ins[15:11];
            imm  = {{16{ins[15]}}, ins[15:0]};
            a    = ref_regs[rs];
            b    = ref_regs[rt];
            addr = a + imm;
            nxt  = pc + 32'd4;
            case (ins[31:26])
                OPC_SPECIAL:
                    case (ins[5:0])
                        FN_ADDU: record_write(rd, a + b);
                        FN_SUBU: record_write(rd, a - b);
                        FN_AND:  record_write(rd, a & b);
                        FN_OR:   record_write(rd, a | b);
                        FN_SLT:  record_write(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                OPC_ADDIU: record_write(rt, addr);
                OPC_LW:    record_write(rt, ref_dmem[addr[9:2]]);
                OPC_SW:
                begin
                    ref_dmem[addr[9:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                OPC_BEQ: if (a == b) nxt = pc + 32'd4 + {imm[29:0], 2'b00};
                OPC_BNE: if (a != b) nxt = pc + 32'd4 + {imm[29:0], 2'b00};
                OPC_J:   nxt = {nxt[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            pc = nxt;
            steps++;
        end
        if (pc != LOOP_PC)
        begin
            $display("The ISA model never reached the final loop");
            abort_run();
        end
        model_wb_total = exp_wb_addr.size();
        model_st_total = exp_st_addr.size();
    endtask

    function automatic logic [31:0] imem_word(logic [31:0] addr);
        logic [31:0] off;
        off = addr - `CPU_RESET_PC;
        if ($isunknown(addr) || off >= 32'(4 * N_INSTR))
            return 32'h0;                  // Past the program reads as nop
        return prog[off >> 2];
    endfunction

    task automatic drive_inputs();
        imem_busy  = rst_n && ($urandom_range(0, 99) < 25);
        imem_rdata = imem_busy ? $urandom() : imem_word(imem_addr);
        if (dmem_req === 1'b1)
        begin
            dmem_busy  = ($urandom_range(0, 99) < 30);
            dmem_rdata = dmem_busy ? $urandom() : dmem[dmem_addr[9:2]];
        end
        else
        begin
            dmem_busy  = 1'b0;
            dmem_rdata = $urandom();       // Junk while nothing is requested
        end
    endtask

    task automatic sample_outputs();
        if (wb_valid === 1'b1)
        begin
            if (exp_wb_addr.size() == 0)
            begin
                $display("Writeback to r%0d at %0t ns with nothing left to retire",
                         wb_addr, $time);
                abort_run();
            end
            else
            begin
                check("wb_addr", 32'(wb_addr), 32'(exp_wb_addr.pop_front()));
                check("wb_data", wb_data, exp_wb_data.pop_front());
                wb_count++;
            end
        end
        if (dmem_req === 1'b1 && (dmem_addr[31:10] != 0 || dmem_addr[1:0] != 0))
        begin
            $display("Data access at %0t ns to %h is outside the test memory",
                     $time, dmem_addr);
            abort_run();
        end
        else if (dmem_req === 1'b1 && dmem_we === 1'b1 && !dmem_busy)
        begin
            if (exp_st_addr.size() == 0)
            begin
                $display("Store to %h at %0t ns that the program never made",
                         dmem_addr, $time);
                abort_run();
            end
            else
            begin
                check("dmem_addr", dmem_addr, exp_st_addr.pop_front());
                check("dmem_wdata", dmem_wdata, exp_st_data.pop_front());
                dmem[dmem_addr[9:2]] = dmem_wdata;
                st_count++;
            end
        end
    endtask

    // Outputs settle well before the next rising edge
    task automatic next_cycle();
        @(negedge clk);
        drive_inputs();
        #2;
        sample_outputs();
    endtask

    initial
    begin : main
        void'($urandom(32'h29c7));
        rst_n      = 1'b0;
        imem_rdata = '0;
        imem_busy  = 1'b0;
        dmem_rdata = '0;
        dmem_busy  = 1'b0;
        wb_count   = 0;
        st_count   = 0;
        for (int a = 0; a < DMEM_WORDS; a++)
        begin
            dmem[a]     = fill_word(32'(4 * a));
            ref_dmem[a] = dmem[a];
        end
        build_program();
        run_model();
        $display("Model expects %0d writebacks and %0d stores", model_wb_total, model_st_total);

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        drive_inputs();
        while (imem_addr !== LOOP_PC)
            next_cycle();
        repeat (DRAIN_CYCLES) next_cycle();    // Older instructions drain while the loop spins

        check("wb_count", wb_count, model_wb_total);
        check("store_count", st_count, model_st_total);
        $display("PASS: all tests");
        $finish;
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the program did not finish", TIMEOUT_NS);
        abort_run();
    end

endmodule

/* flist.f */
+incdir+.
cpu_pkg.sv
hazard_if.sv
regfile.sv
decode_stage.sv
execute_stage.sv
hazard.sv
cpu_top.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: mips_pipe

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - hazard_if.sv
      - regfile.sv
      - decode_stage.sv
      - execute_stage.sv
      - hazard.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv
